//--- mips_pkg.sv
package mips_pkg;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	// funct field of r-type words
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} j_fmt_t;

	// one instruction word, three ways to look at it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE, BR_EQ, BR_NE, BR_UNCOND
	} branch_op_e;

	typedef struct packed {
		logic        valid;
		instr_t      instr;
		logic [31:0] next_pc; // pc of the word plus 4
	} if2id_t;

	typedef struct packed {
		logic        valid;
		alu_op_e     alu_op;
		logic        use_imm;     // imm replaces operand_b in the alu
		logic [31:0] operand_a;   // rs value
		logic [31:0] operand_b;   // rt value
		logic [31:0] imm;         // already extended or shifted
		logic [4:0]  shamt;
		branch_op_e  branch_op;
		logic [31:0] branch_dest;
		logic [4:0]  wb_addr;     // 0 means no write
	} id2ex_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  wb_addr;
		logic [31:0] wb_data;
	} ex2wb_t;

endpackage

//--- fetch_stage.sv
module fetch_stage #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	input  logic              imem_we,
	input  logic [31:0]       imem_addr,   // byte address, word aligned
	input  mips_pkg::instr_t  imem_data,
	input  logic              redirect,
	input  logic [31:0]       redirect_pc,
	output mips_pkg::if2id_t  if2id
);
	import mips_pkg::*;

	localparam int ADDR_W = $clog2(IMEM_DEPTH);

	instr_t imem [IMEM_DEPTH];

	logic [31:0]       pc;
	logic [31:0]       pc_plus4;
	logic [ADDR_W-1:0] pc_index;
	logic [ADDR_W-1:0] load_index;
	instr_t            fetched;

	assign pc_plus4   = pc + 32'd4;
	assign pc_index   = pc[ADDR_W+1:2];
	assign load_index = imem_addr[ADDR_W+1:2];
	assign fetched    = imem[pc_index]; // async read, registered below

	// loader port, used while run is low
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[load_index] <= imem_data;
	end

	// program counter
	always_ff @(posedge clk) begin
		if (reset || !run)
			pc <= '0; // parked at the reset vector
		else if (redirect)
			pc <= redirect_pc;
		else
			pc <= pc_plus4;
	end

	// if-to-id register; a redirect cycle turns the fetched word into a bubble
	always_ff @(posedge clk) begin
		if2id.valid   <= 1'b1;
		if2id.instr   <= fetched;
		if2id.next_pc <= pc_plus4;
		if (reset || !run || redirect)
			if2id.valid <= 1'b0;
	end

endmodule

//--- register_file.sv
module register_file (
	input  logic             clk,
	input  logic             reset,
	input  logic [4:0]       read1_addr,
	input  logic [4:0]       read2_addr,
	output logic [31:0]      read1_data,
	output logic [31:0]      read2_data,
	input  mips_pkg::ex2wb_t write,
	input  logic [4:0]       dbg_addr,
	output logic [31:0]      dbg_data
);

	logic [31:0] regs [32];

	// read with bypass of the write landing this cycle
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		if (write.valid && write.wb_addr == addr)
			return write.wb_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write.valid && write.wb_addr != 5'd0) begin
			regs[write.wb_addr] <= write.wb_data;
		end
	end

	// reads follow the stored registers and the incoming write
	always_comb begin
		read1_data = read_port(read1_addr);
		read2_data = read_port(read2_addr);
		dbg_data   = read_port(dbg_addr);   // combinational debug view
	end

endmodule

//--- decode_stage.sv
module decode_stage (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  mips_pkg::if2id_t if2id,
	input  mips_pkg::ex2wb_t write,
	input  logic [4:0]       dbg_addr,
	output logic [31:0]      dbg_data,
	output mips_pkg::id2ex_t id2ex
);
	import mips_pkg::*;

	instr_t      instr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	id2ex_t      dec;

	assign instr = if2id.instr;

	assign imm_sext = {{16{instr.i_fmt.imm16[15]}}, instr.i_fmt.imm16};
	assign imm_zext = {16'h0000, instr.i_fmt.imm16};

	// offsets count words relative to the slot after the branch
	assign branch_target = if2id.next_pc + {imm_sext[29:0], 2'b00};
	assign jump_target   = {if2id.next_pc[31:28], instr.j_fmt.target26, 2'b00};

	register_file u_regfile (
		.clk        (clk),
		.reset      (reset),
		.read1_addr (instr.r_fmt.rs),
		.read2_addr (instr.r_fmt.rt),
		.read1_data (rs_data),
		.read2_data (rt_data),
		.write      (write),
		.dbg_addr   (dbg_addr),
		.dbg_data   (dbg_data)
	);

	always_comb begin
		dec             = '0;
		dec.valid       = if2id.valid;
		dec.operand_a   = rs_data;
		dec.operand_b   = rt_data;
		dec.shamt       = instr.r_fmt.shamt;
		dec.imm         = imm_sext;
		dec.alu_op      = ALU_NONE;
		dec.branch_op   = BR_NONE;
		dec.branch_dest = branch_target;

		case (instr.r_fmt.opcode)
			OP_RTYPE: begin
				dec.wb_addr = instr.r_fmt.rd;
				case (instr.r_fmt.funct)
					FN_ADDU: dec.alu_op = ALU_ADDU;
					FN_SUBU: dec.alu_op = ALU_SUBU;
					FN_AND:  dec.alu_op = ALU_AND;
					FN_OR:   dec.alu_op = ALU_OR;
					FN_XOR:  dec.alu_op = ALU_XOR;
					FN_SLT:  dec.alu_op = ALU_SLT;
					FN_SLL:  dec.alu_op = ALU_SLL;
					FN_SRL:  dec.alu_op = ALU_SRL;
					default: begin
						dec.valid   = 1'b0; // unknown funct
						dec.wb_addr = '0;
					end
				endcase
			end
			OP_ADDIU: begin
				dec.alu_op  = ALU_ADDU;
				dec.use_imm = 1'b1;
				dec.wb_addr = instr.i_fmt.rt;
			end
			OP_ORI: begin
				dec.alu_op  = ALU_OR;
				dec.use_imm = 1'b1;
				dec.imm     = imm_zext;
				dec.wb_addr = instr.i_fmt.rt;
			end
			OP_LUI: begin
				dec.alu_op  = ALU_LUI;
				dec.use_imm = 1'b1;
				dec.imm     = {instr.i_fmt.imm16, 16'h0000};
				dec.wb_addr = instr.i_fmt.rt;
			end
			OP_BEQ: dec.branch_op = BR_EQ;
			OP_BNE: dec.branch_op = BR_NE;
			OP_J: begin
				dec.branch_op   = BR_UNCOND;
				dec.branch_dest = jump_target;
			end
			default: dec.valid = 1'b0; // unknown opcode becomes a bubble
		endcase
	end

	// id-to-ex register
	always_ff @(posedge clk) begin
		id2ex <= dec;
		if (reset || flush)
			id2ex.valid <= 1'b0;
	end

endmodule

//--- execute_stage.sv
module execute_stage (
	input  logic             clk,
	input  logic             reset,
	input  mips_pkg::id2ex_t id2ex,
	output logic             redirect,
	output logic [31:0]      redirect_pc,
	output mips_pkg::ex2wb_t ex2wb
);
	import mips_pkg::*;

	logic [31:0] b_sel;
	logic [31:0] alu_result;
	logic        taken;
	logic        live;

	// the instruction behind a taken branch is still in id2ex while redirect is high
	assign live  = id2ex.valid && !redirect;
	assign b_sel = id2ex.use_imm ? id2ex.imm : id2ex.operand_b;

	always_comb begin
		case (id2ex.alu_op)
			ALU_ADDU: alu_result = id2ex.operand_a + b_sel;
			ALU_SUBU: alu_result = id2ex.operand_a - b_sel;
			ALU_AND:  alu_result = id2ex.operand_a & b_sel;
			ALU_OR:   alu_result = id2ex.operand_a | b_sel;
			ALU_XOR:  alu_result = id2ex.operand_a ^ b_sel;
			ALU_SLT:  alu_result = {31'd0, $signed(id2ex.operand_a) < $signed(b_sel)};
			ALU_SLL:  alu_result = id2ex.operand_b << id2ex.shamt;
			ALU_SRL:  alu_result = id2ex.operand_b >> id2ex.shamt;
			ALU_LUI:  alu_result = b_sel; // imm arrives pre-shifted
			default:  alu_result = '0;
		endcase
	end

	// branch resolution, rs against rt
	always_comb begin
		case (id2ex.branch_op)
			BR_EQ:     taken = id2ex.operand_a == id2ex.operand_b;
			BR_NE:     taken = id2ex.operand_a != id2ex.operand_b;
			BR_UNCOND: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		redirect    <= live && taken;
		redirect_pc <= id2ex.branch_dest;
		if (reset)
			redirect <= 1'b0;
	end

	// ex-to-wb register; r0 targets never show up as writebacks
	always_ff @(posedge clk) begin
		ex2wb.valid   <= live && (id2ex.wb_addr != 5'd0);
		ex2wb.wb_addr <= id2ex.wb_addr;
		ex2wb.wb_data <= alu_result;
		if (reset)
			ex2wb.valid <= 1'b0;
	end

endmodule

//--- mips_core.sv
module mips_core #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             run,
	input  logic             imem_we,
	input  logic [31:0]      imem_addr,
	input  mips_pkg::instr_t imem_data,
	output logic             wb_valid,
	output logic [4:0]       wb_addr,
	output logic [31:0]      wb_data,
	input  logic [4:0]       dbg_addr,
	output logic [31:0]      dbg_data
);
	import mips_pkg::*;

	if2id_t      if2id;
	id2ex_t      id2ex;
	ex2wb_t      ex2wb;
	logic        redirect;    // also flushes decode
	logic [31:0] redirect_pc;

	fetch_stage #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) u_fetch (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.if2id       (if2id)
	);

	decode_stage u_decode (
		.clk      (clk),
		.reset    (reset),
		.flush    (redirect),
		.if2id    (if2id),
		.write    (ex2wb),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data),
		.id2ex    (id2ex)
	);

	execute_stage u_execute (
		.clk         (clk),
		.reset       (reset),
		.id2ex       (id2ex),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex2wb       (ex2wb)
	);

	// retirement strobe
	assign wb_valid = ex2wb.valid;
	assign wb_addr  = ex2wb.wb_addr;
	assign wb_data  = ex2wb.wb_data;

endmodule

//--- tb_mips_programs.svh
// directed programs, one step per instruction word
// columns of a step: program, instruction, retired register (0 for none), retired value
localparam int NUM_PROGS = 5;
localparam int MAX_STEPS = 16;

string       prog_name [NUM_PROGS];
instr_t      prog_word [NUM_PROGS][MAX_STEPS];
int          prog_len  [NUM_PROGS];
logic [4:0]  exp_addr  [NUM_PROGS][MAX_STEPS];
logic [31:0] exp_data  [NUM_PROGS][MAX_STEPS];
int          exp_count [NUM_PROGS];

task automatic step(input int p, input instr_t w, input logic [4:0] a, input logic [31:0] d);
	prog_word[p][prog_len[p]] = w;
	prog_len[p]++;
	if (a != 5'd0) begin
		exp_addr[p][exp_count[p]] = a;
		exp_data[p][exp_count[p]] = d;
		exp_count[p]++;
	end
endtask

task automatic build_programs();
	prog_name[0] = "alu_ops";
	step(0, i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0005), 5'd1, 32'h0000_0005);
	step(0, i_word(OP_ADDIU, 5'd2, 5'd0, 16'hfffd), 5'd2, 32'hffff_fffd); // -3
	step(0, i_word(OP_LUI, 5'd3, 5'd0, 16'h1234), 5'd3, 32'h1234_0000);
	step(0, r_word(FN_ADDU, 5'd4, 5'd1, 5'd2, 5'd0), 5'd4, 32'h0000_0002);
	step(0, r_word(FN_SUBU, 5'd5, 5'd1, 5'd2, 5'd0), 5'd5, 32'h0000_0008);
	step(0, i_word(OP_ORI, 5'd6, 5'd3, 16'h8767), 5'd6, 32'h1234_8767); // zero extended
	step(0, r_word(FN_XOR, 5'd7, 5'd1, 5'd2, 5'd0), 5'd7, 32'hffff_fff8);
	step(0, r_word(FN_AND, 5'd8, 5'd6, 5'd2, 5'd0), 5'd8, 32'h1234_8765);
	step(0, r_word(FN_OR, 5'd9, 5'd1, 5'd3, 5'd0), 5'd9, 32'h1234_0005);
	step(0, r_word(FN_SLT, 5'd10, 5'd2, 5'd1, 5'd0), 5'd10, 32'h0000_0001); // -3 < 5
	step(0, r_word(FN_SLL, 5'd11, 5'd0, 5'd1, 5'd4), 5'd11, 32'h0000_0050);
	step(0, r_word(FN_SRL, 5'd12, 5'd0, 5'd2, 5'd28), 5'd12, 32'h0000_000f);
	step(0, r_word(FN_SLT, 5'd13, 5'd7, 5'd2, 5'd0), 5'd13, 32'h0000_0001); // -8 < -3
	prog_name[1] = "reg_zero";
	step(1, i_word(OP_ADDIU, 5'd0, 5'd0, 16'h0007), 5'd0, 32'h0);
	step(1, i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0009), 5'd1, 32'h0000_0009);
	step(1, i_word(OP_ORI, 5'd0, 5'd0, 16'hffff), 5'd0, 32'h0);
	step(1, r_word(FN_ADDU, 5'd2, 5'd0, 5'd1, 5'd0), 5'd2, 32'h0000_0009);
	step(1, r_word(FN_OR, 5'd3, 5'd0, 5'd0, 5'd0), 5'd3, 32'h0000_0000);
	prog_name[2] = "write_through";
	step(2, i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0010), 5'd1, 32'h0000_0010);
	step(2, i_word(OP_ADDIU, 5'd2, 5'd0, 16'h0020), 5'd2, 32'h0000_0020);
	step(2, r_word(FN_ADDU, 5'd3, 5'd1, 5'd1, 5'd0), 5'd3, 32'h0000_0020);
	step(2, i_word(OP_ADDIU, 5'd4, 5'd2, 16'h0001), 5'd4, 32'h0000_0021);
	step(2, r_word(FN_SUBU, 5'd5, 5'd3, 5'd1, 5'd0), 5'd5, 32'h0000_0010);
	step(2, r_word(FN_ADDU, 5'd6, 5'd4, 5'd3, 5'd0), 5'd6, 32'h0000_0041);
	prog_name[3] = "branches";
	step(3, i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0003), 5'd1, 32'h0000_0003);
	step(3, i_word(OP_ADDIU, 5'd2, 5'd0, 16'h0003), 5'd2, 32'h0000_0003);
	step(3, i_word(OP_ADDIU, 5'd3, 5'd0, 16'h0004), 5'd3, 32'h0000_0004);
	step(3, i_word(OP_BEQ, 5'd2, 5'd1, 16'h0002), 5'd0, 32'h0); // taken, to word 6
	step(3, i_word(OP_ADDIU, 5'd10, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_ADDIU, 5'd11, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_BNE, 5'd3, 5'd1, 16'h0002), 5'd0, 32'h0); // taken, to word 9
	step(3, i_word(OP_ADDIU, 5'd12, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_ADDIU, 5'd13, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_BEQ, 5'd3, 5'd1, 16'h0005), 5'd0, 32'h0); // falls through
	step(3, i_word(OP_ADDIU, 5'd4, 5'd0, 16'h0044), 5'd4, 32'h0000_0044);
	step(3, j_word(26'd14), 5'd0, 32'h0);
	step(3, i_word(OP_ADDIU, 5'd14, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_ADDIU, 5'd15, 5'd0, 16'h0001), 5'd0, 32'h0);
	step(3, i_word(OP_ADDIU, 5'd5, 5'd4, 16'h0001), 5'd5, 32'h0000_0045);
	prog_name[4] = "unknown_ops";
	step(4, i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0011), 5'd1, 32'h0000_0011);
	step(4, i_word(6'h3f, 5'd2, 5'd0, 16'h1234), 5'd0, 32'h0);
	step(4, i_word(OP_ADDIU, 5'd3, 5'd1, 16'h0001), 5'd3, 32'h0000_0012);
	step(4, r_word(6'h3f, 5'd4, 5'd1, 5'd1, 5'd0), 5'd0, 32'h0); // bad funct
	step(4, r_word(FN_ADDU, 5'd5, 5'd3, 5'd1, 5'd0), 5'd5, 32'h0000_0023);
	step(4, i_word(OP_ADDIU, 5'd6, 5'd2, 16'h0000), 5'd6, 32'h0000_0000);
endtask

//--- tb_mips_core.sv
module tb_mips_core;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;

	localparam int IMEM_DEPTH    = 256;
	localparam int WB_TIMEOUT    = 200; // cycles
	localparam int SETTLE_CYCLES = 12;
	localparam int RANDOM_LEN    = 24;

	logic        clk;
	logic        reset;
	logic        run;
	logic        imem_we;
	logic [31:0] imem_addr;
	instr_t      imem_data;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic [4:0]  dbg_addr;
	logic [31:0] dbg_data;

	instr_t      cur_words [$];
	logic [4:0]  cur_addr [$];
	logic [31:0] cur_data [$];
	logic [31:0] model [32]; // reference registers for the random program
	int          test_errors;
	int          pass_count;
	int          fail_count;

	mips_core #(.IMEM_DEPTH (IMEM_DEPTH)) u_dut (
		.clk (clk), .reset (reset), .run (run),
		.imem_we (imem_we), .imem_addr (imem_addr), .imem_data (imem_data),
		.wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
		.dbg_addr (dbg_addr), .dbg_data (dbg_data)
	);

	always #5 clk = ~clk;

	function automatic instr_t r_word(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic instr_t i_word(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instr_t j_word(input logic [25:0] target);
		return {OP_J, target};
	endfunction

	// unknown opcode tagged with the word index so leftover code never retires
	function automatic instr_t fill_word(input int idx);
		return {6'h3f, 26'(idx)};
	endfunction

	`include "tb_mips_programs.svh"

	task automatic reset_core();
		@(posedge clk);
		reset   <= 1'b1;
		run     <= 1'b0;
		imem_we <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic load_program();
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			@(posedge clk);
			imem_we   <= 1'b1;
			imem_addr <= 32'(a * 4);
			imem_data <= (a < cur_words.size()) ? cur_words[a] : fill_word(a);
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	task automatic run_test(input string name);
		logic [4:0]  got_addr [$];
		logic [31:0] got_data [$];
		int          cycles;
		int          extra;
		test_errors = 0;
		reset_core();
		load_program();
		@(posedge clk);
		run <= 1'b1;
		cycles = 0;
		while (got_addr.size() < cur_addr.size() && cycles < WB_TIMEOUT) begin
			@(negedge clk); // outputs settled
			cycles++;
			if (wb_valid) begin
				got_addr.push_back(wb_addr);
				got_data.push_back(wb_data);
			end
		end
		extra = 0;
		repeat (SETTLE_CYCLES) begin
			@(negedge clk);
			if (wb_valid)
				extra++;
		end
		assert (got_addr.size() == cur_addr.size()) else begin
			$display("%s: timed out, only %0d of %0d writebacks arrived within %0d cycles",
				name, got_addr.size(), cur_addr.size(), WB_TIMEOUT);
			test_errors++;
		end
		assert (extra == 0) else begin
			$display("%s: %0d writebacks arrived that the program should not retire",
				name, extra);
			test_errors++;
		end
		for (int k = 0; k < got_addr.size(); k++) begin
			assert (got_addr[k] == cur_addr[k] && got_data[k] == cur_data[k]) else begin
				$display("ERROR %s: writeback %0d expected r%0d = %h, actual r%0d = %h",
					name, k, cur_addr[k], cur_data[k], got_addr[k], got_data[k]);
				test_errors++;
			end
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	// ADDIU and ADDU only; a source never names the previous destination
	task automatic make_random_program();
		int          dest;
		int          rs;
		int          rt;
		int          prev_dest;
		logic [15:0] imm;
		logic [31:0] value;
		cur_words = {};
		cur_addr  = {};
		cur_data  = {};
		for (int r = 0; r < 32; r++)
			model[r] = '0;
		prev_dest = 0;
		for (int i = 0; i < RANDOM_LEN; i++) begin
			dest = $urandom_range(15, 0);
			rs   = $urandom_range(15, 0);
			rt   = $urandom_range(15, 0);
			if (rs == prev_dest)
				rs = 0;
			if (rt == prev_dest)
				rt = 0;
			if ($urandom_range(1, 0) == 1) begin
				imm   = 16'($urandom);
				value = model[rs] + {{16{imm[15]}}, imm};
				cur_words.push_back(i_word(OP_ADDIU, 5'(dest), 5'(rs), imm));
			end else begin
				value = model[rs] + model[rt];
				cur_words.push_back(r_word(FN_ADDU, 5'(dest), 5'(rs), 5'(rt), 5'd0));
			end
			if (dest != 0) begin // r0 retires nothing
				model[dest] = value;
				cur_addr.push_back(5'(dest));
				cur_data.push_back(value);
			end
			prev_dest = dest;
		end
	endtask

	task automatic check_registers(input string name);
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			dbg_addr <= 5'(r);
			@(negedge clk);
			assert (dbg_data == model[r]) else begin
				$display("ERROR %s: debug read r%0d expected %h, actual %h",
					name, r, model[r], dbg_data);
				test_errors++;
			end
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: pass, %0d writebacks", name, cur_addr.size());
		end else begin
			fail_count++;
			$display("%s: fail, %0d errors", name, test_errors);
		end
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		run       = 1'b0;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		dbg_addr  = '0;
		void'($urandom(32'hfe3e));
		build_programs();
		for (int p = 0; p < NUM_PROGS; p++) begin
			cur_words = {};
			cur_addr  = {};
			cur_data  = {};
			for (int i = 0; i < prog_len[p]; i++)
				cur_words.push_back(prog_word[p][i]);
			for (int i = 0; i < exp_count[p]; i++) begin
				cur_addr.push_back(exp_addr[p][i]);
				cur_data.push_back(exp_data[p][i]);
			end
			run_test(prog_name[p]);
			report_test(prog_name[p]);
		end
		make_random_program();
		run_test("random_addu");
		check_registers("random_addu");
		report_test("random_addu");
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- mips_core.f
+incdir+.
mips_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
tb_mips_core.sv
